// ==== design/periph_pkg.sv ====
/*
 * Shared peripheral definitions: AXI4-Lite request and response structs,
 * response codes, register address map and timing constants
 */
`default_nettype none

package periph_pkg;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_e;

    // Everything the master drives
    typedef struct packed {
        logic [7:0]  awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
        logic [7:0]  araddr;
        logic        arvalid;
        logic        rready;
    } axil_req_t;

    // Everything the slave drives
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        axil_resp_e  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        axil_resp_e  rresp;
    } axil_rsp_t;

    // Peripheral register map
    localparam logic [7:0] ADDR_GPIO_OUT    = 8'h00;
    localparam logic [7:0] ADDR_GPIO_IN     = 8'h04;
    localparam logic [7:0] ADDR_GPIO_SEL    = 8'h0C;
    localparam logic [7:0] ADDR_UART_DATA   = 8'h10;
    localparam logic [7:0] ADDR_UART_STATUS = 8'h14;
    localparam logic [7:0] ADDR_PWM         = 8'h28;

    // Short bit period keeps simulation frames brief
    localparam int UART_CLKS_PER_BIT = 8;
    localparam int UART_CNT_W        = $clog2(UART_CLKS_PER_BIT);

    localparam int PWM_WIDTH = 8;

endpackage

`default_nettype wire

// ==== design/axil_arbiter.sv ====
/*
 * Round-robin arbiter joining two AXI4-Lite masters onto one slave port,
 * one transaction per grant
 */
`timescale 1ns/100ps
`default_nettype none

module axil_arbiter (
    input  logic                  clk,
    input  logic                  rst_reg_n,
    input  periph_pkg::axil_req_t m0_req,
    output periph_pkg::axil_rsp_t m0_rsp,
    input  periph_pkg::axil_req_t m1_req,
    output periph_pkg::axil_rsp_t m1_rsp,
    output periph_pkg::axil_req_t s_req,
    input  periph_pkg::axil_rsp_t s_rsp
);
    import periph_pkg::*;

    logic [1:0] grant;
    logic       last_win;
    logic       is_write;
    logic       req0;
    logic       req1;
    logic       pick1;
    logic       done;
    axil_req_t  sel_req;
    axil_rsp_t  gated_rsp;

    assign req0 = m0_req.awvalid | m0_req.arvalid;
    assign req1 = m1_req.awvalid | m1_req.arvalid;

    // Master 1 takes it when alone, or on a tie after master 0 won last
    assign pick1 = req1 & (~req0 | ~last_win);

    // Grant ends on the B or R handshake of its own transaction
    assign done = is_write ? (s_rsp.bvalid & s_req.bready)
                           : (s_rsp.rvalid & s_req.rready);

    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            grant    <= 2'b00;
            last_win <= 1'b1;
            is_write <= 1'b0;
        end else if (grant == 2'b00) begin
            if (req0 | req1) begin
                grant    <= pick1 ? 2'b10 : 2'b01;
                last_win <= pick1;
                // Write goes first if the winner has both
                is_write <= pick1 ? m1_req.awvalid : m0_req.awvalid;
            end
        end else if (done) begin
            grant <= 2'b00;
        end
    end

    // Forward only the channel group of the granted transaction
    always_comb begin
        sel_req = grant[1] ? m1_req : m0_req;
        s_req   = '0;
        if (grant != 2'b00) begin
            if (is_write) begin
                s_req.awaddr  = sel_req.awaddr;
                s_req.awvalid = sel_req.awvalid;
                s_req.wdata   = sel_req.wdata;
                s_req.wstrb   = sel_req.wstrb;
                s_req.wvalid  = sel_req.wvalid;
                s_req.bready  = sel_req.bready;
            end else begin
                s_req.araddr  = sel_req.araddr;
                s_req.arvalid = sel_req.arvalid;
                s_req.rready  = sel_req.rready;
            end
        end
    end

    // Hide the other channel group so a waiting read is not accepted early
    always_comb begin
        gated_rsp = s_rsp;
        if (is_write) begin
            gated_rsp.arready = 1'b0;
            gated_rsp.rvalid  = 1'b0;
        end else begin
            gated_rsp.awready = 1'b0;
            gated_rsp.wready  = 1'b0;
            gated_rsp.bvalid  = 1'b0;
        end
        m0_rsp = grant[0] ? gated_rsp : '0;
        m1_rsp = grant[1] ? gated_rsp : '0;
    end

    // A slave response only exists while some master holds the grant
    a_rsp_granted: assert property (@(posedge clk) disable iff (!rst_reg_n)
        grant == 2'b00 |-> !s_rsp.bvalid && !s_rsp.rvalid);

    a_grant_held: assert property (@(posedge clk) disable iff (!rst_reg_n)
        (s_rsp.bvalid || s_rsp.rvalid) && !done |=> $stable(grant));

endmodule

`default_nettype wire

// ==== design/periph_regs.sv ====
/*
 * AXI4-Lite register block: address decode, GPIO registers, read mux,
 * output pin mux and UART/PWM strobes
 */
`timescale 1ns/100ps
`default_nettype none

module periph_regs (
    input  logic                                clk,
    input  logic                                rst_reg_n,
    input  periph_pkg::axil_req_t               s_req,
    output periph_pkg::axil_rsp_t               s_rsp,
    input  logic [7:0]                          gpio_in,
    output logic [7:0]                          uo_out,
    output logic                                uart_start,
    output logic [7:0]                          uart_data,
    input  logic                                uart_busy,
    input  logic                                uart_txd,
    output logic                                pwm_set,
    output logic [periph_pkg::PWM_WIDTH-1:0]    pwm_level,
    input  logic                                pwm
);
    import periph_pkg::*;

    logic [7:0]           gpio_out;
    logic [8:0]           gpio_sel;
    logic [7:0]           gpio_in_meta;
    logic [7:0]           gpio_in_sync;
    logic                 wr_hs;
    logic                 rd_hs;
    logic                 wr_mapped;
    logic                 rd_mapped;
    logic [31:0]          rd_data;
    logic                 bvalid_q;
    axil_resp_e           bresp_q;
    logic                 rvalid_q;
    logic [31:0]          rdata_q;
    axil_resp_e           rresp_q;
    logic                 pwm_set_q;
    logic [PWM_WIDTH-1:0] pwm_level_q;

    function automatic logic addr_mapped(input logic [7:0] addr);
        return addr == ADDR_GPIO_OUT || addr == ADDR_GPIO_IN ||
               addr == ADDR_GPIO_SEL || addr == ADDR_UART_DATA ||
               addr == ADDR_UART_STATUS || addr == ADDR_PWM;
    endfunction

    // Address and data are taken together, one outstanding response each way
    assign wr_hs     = s_req.awvalid & s_req.wvalid & ~bvalid_q;
    assign rd_hs     = s_req.arvalid & ~rvalid_q;
    assign wr_mapped = addr_mapped(s_req.awaddr);

    always_ff @(posedge clk) begin
        gpio_in_meta <= gpio_in;
        gpio_in_sync <= gpio_in_meta;
    end

    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            gpio_out    <= '0;
            gpio_sel    <= '0;
            pwm_set_q   <= 1'b0;
            pwm_level_q <= '0;
        end else begin
            pwm_set_q <= 1'b0;
            if (wr_hs && s_req.awaddr == ADDR_GPIO_OUT && s_req.wstrb[0])
                gpio_out <= s_req.wdata[7:0];
            if (wr_hs && s_req.awaddr == ADDR_GPIO_SEL) begin
                if (s_req.wstrb[0])
                    gpio_sel[7:0] <= s_req.wdata[7:0];
                if (s_req.wstrb[1])
                    gpio_sel[8] <= s_req.wdata[8];
            end
            if (wr_hs && s_req.awaddr == ADDR_PWM && s_req.wstrb[0]) begin
                pwm_set_q   <= 1'b1;
                pwm_level_q <= s_req.wdata[PWM_WIDTH-1:0];
            end
        end
    end

    // UART drops the byte itself when already sending
    assign uart_start = wr_hs & (s_req.awaddr == ADDR_UART_DATA) & s_req.wstrb[0];
    assign uart_data  = s_req.wdata[7:0];
    assign pwm_set    = pwm_set_q;
    assign pwm_level  = pwm_level_q;

    // Pin mux
    assign uo_out[0]   = gpio_sel[0] ? gpio_out[0] : uart_txd;
    assign uo_out[6:1] = gpio_sel[6:1] & gpio_out[6:1];
    assign uo_out[7]   = gpio_sel[8] ? pwm : (gpio_sel[7] & gpio_out[7]);

    always_comb begin
        rd_mapped = 1'b1;
        case (s_req.araddr)
            ADDR_GPIO_OUT:    rd_data = {24'h0, uo_out};
            ADDR_GPIO_IN:     rd_data = {24'h0, gpio_in_sync};
            ADDR_GPIO_SEL:    rd_data = {23'h0, gpio_sel};
            ADDR_UART_DATA:   rd_data = '0;
            ADDR_UART_STATUS: rd_data = {31'h0, uart_busy};
            ADDR_PWM:         rd_data = {{(32 - PWM_WIDTH){1'b0}}, pwm_level_q};
            default: begin
                rd_data   = '1;
                rd_mapped = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            if (wr_hs)
                bvalid_q <= 1'b1;
            else if (s_req.bready)
                bvalid_q <= 1'b0;
            if (rd_hs)
                rvalid_q <= 1'b1;
            else if (s_req.rready)
                rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hs)
            bresp_q <= wr_mapped ? OKAY : SLVERR;
        if (rd_hs) begin
            rdata_q <= rd_data;
            rresp_q <= rd_mapped ? OKAY : SLVERR;
        end
    end

    always_comb begin
        s_rsp         = '0;
        s_rsp.awready = wr_hs;
        s_rsp.wready  = wr_hs;
        s_rsp.bvalid  = bvalid_q;
        s_rsp.bresp   = bresp_q;
        s_rsp.arready = rd_hs;
        s_rsp.rvalid  = rvalid_q;
        s_rsp.rdata   = rdata_q;
        s_rsp.rresp   = rresp_q;
    end

    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_reg_n)
        s_rsp.bvalid && !s_req.bready |=> s_rsp.bvalid && $stable(s_rsp.bresp));

endmodule

`default_nettype wire

// ==== design/uart_tx.sv ====
/*
 * 8N1 serial transmitter with busy flag
 */
`timescale 1ns/100ps
`default_nettype none

module uart_tx (
    input  logic       clk,
    input  logic       rst_reg_n,
    input  logic       start,
    input  logic [7:0] data,
    output logic       txd,
    output logic       busy
);
    import periph_pkg::*;

    logic [UART_CNT_W-1:0] clk_cnt;
    logic [3:0]            bit_idx;
    logic [9:0]            shift;
    logic                  bit_end;

    assign bit_end = (clk_cnt == UART_CNT_W'(UART_CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            busy    <= 1'b0;
            clk_cnt <= '0;
            bit_idx <= '0;
        end else if (!busy) begin
            if (start) begin
                busy    <= 1'b1;
                clk_cnt <= '0;
                bit_idx <= '0;
            end
        end else if (bit_end) begin
            clk_cnt <= '0;
            bit_idx <= bit_idx + 4'd1;
            // Stop bit is index 9
            if (bit_idx == 4'd9)
                busy <= 1'b0;
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    // Frame is stop, data, start from msb down, sent from bit 0
    always_ff @(posedge clk) begin
        if (!busy && start)
            shift <= {1'b1, data, 1'b0};
        else if (busy && bit_end)
            shift <= {1'b1, shift[9:1]};
    end

    // Line idles high
    assign txd = busy ? shift[0] : 1'b1;

    // Stop bit drives the line high up to the end of the frame
    a_stop_high: assert property (@(posedge clk) disable iff (!rst_reg_n)
        busy && bit_end && bit_idx == 4'd9 |-> txd);

endmodule

`default_nettype wire

// ==== design/pwm_ctrl.sv ====
/*
 * Free-running PWM with level reloaded at counter wrap
 */
`timescale 1ns/100ps
`default_nettype none

module pwm_ctrl (
    input  logic                             clk,
    input  logic                             rst_reg_n,
    input  logic                             set,
    input  logic [periph_pkg::PWM_WIDTH-1:0] level,
    output logic                             pwm
);
    import periph_pkg::*;

    logic [PWM_WIDTH-1:0] count;
    logic [PWM_WIDTH-1:0] pending;
    logic [PWM_WIDTH-1:0] active;
    logic                 wrap;

    assign wrap = (count == {PWM_WIDTH{1'b1}});

    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            count   <= '0;
            pending <= '0;
            active  <= '0;
        end else begin
            count <= count + 1'b1;
            if (set)
                pending <= level;
            // A level written on the wrap cycle still makes this period
            if (wrap)
                active <= set ? level : pending;
        end
    end

    // Exactly active high cycles per period
    assign pwm = (count < active);

endmodule

`default_nettype wire

// ==== design/periph_top.sv ====
/*
 * Peripheral top: arbiter, register block, UART transmitter and PWM
 */
`timescale 1ns/100ps
`default_nettype none

module periph_top (
    input  logic                  clk,
    input  logic                  rst_reg_n,
    input  periph_pkg::axil_req_t m0_req,
    output periph_pkg::axil_rsp_t m0_rsp,
    input  periph_pkg::axil_req_t m1_req,
    output periph_pkg::axil_rsp_t m1_rsp,
    input  logic [7:0]            gpio_in,
    output logic [7:0]            uo_out
);
    import periph_pkg::*;

    axil_req_t            s_req;
    axil_rsp_t            s_rsp;
    logic                 uart_start;
    logic [7:0]           uart_data;
    logic                 uart_txd;
    logic                 uart_busy;
    logic                 pwm_set;
    logic [PWM_WIDTH-1:0] pwm_level;
    logic                 pwm_out;

    // Processor on port 0, debug host on port 1
    axil_arbiter i_arbiter (
        .clk       (clk),
        .rst_reg_n (rst_reg_n),
        .m0_req    (m0_req),
        .m0_rsp    (m0_rsp),
        .m1_req    (m1_req),
        .m1_rsp    (m1_rsp),
        .s_req     (s_req),
        .s_rsp     (s_rsp)
    );

    periph_regs i_regs (
        .clk        (clk),
        .rst_reg_n  (rst_reg_n),
        .s_req      (s_req),
        .s_rsp      (s_rsp),
        .gpio_in    (gpio_in),
        .uo_out     (uo_out),
        .uart_start (uart_start),
        .uart_data  (uart_data),
        .uart_busy  (uart_busy),
        .uart_txd   (uart_txd),
        .pwm_set    (pwm_set),
        .pwm_level  (pwm_level),
        .pwm        (pwm_out)
    );

    uart_tx i_uart_tx (
        .clk       (clk),
        .rst_reg_n (rst_reg_n),
        .start     (uart_start),
        .data      (uart_data),
        .txd       (uart_txd),
        .busy      (uart_busy)
    );

    pwm_ctrl i_pwm (
        .clk       (clk),
        .rst_reg_n (rst_reg_n),
        .set       (pwm_set),
        .level     (pwm_level),
        .pwm       (pwm_out)
    );

endmodule

`default_nettype wire

// ==== dv/periph_tb.sv ====
/*
 * Testbench for the peripheral top: register table, UART frame, PWM duty,
 * arbitration order and back-pressure checks
 */
`timescale 1ns/100ps
`default_nettype none

module periph_tb;
    import periph_pkg::*;

    localparam int TBL_LEN      = 15;
    localparam int PWM_PERIOD   = 1 << PWM_WIDTH;
    localparam int FRAME_CYCLES = 10 * UART_CLKS_PER_BIT;
    localparam int MAX_CYCLES   = TBL_LEN * 40 + 2 * PWM_PERIOD + 3 * FRAME_CYCLES;

    typedef struct packed {
        logic        m;
        logic        wr;
        logic [7:0]  addr;
        logic [31:0] wdata;
        logic [31:0] rdata;
        axil_resp_e  resp;
    } step_t;

    logic       clk;
    logic       rst_reg_n;
    axil_req_t  req [0:1];
    axil_rsp_t  rsp [0:1];
    axil_req_t  m0_req;
    axil_req_t  m1_req;
    axil_rsp_t  m0_rsp;
    axil_rsp_t  m1_rsp;
    logic [7:0] gpio_in;
    logic [7:0] uo_out;

    step_t tbl [0:TBL_LEN-1];
    int    n_steps;
    int    cycle;
    int    errors;
    int    err_mark;
    int    n_tests;
    int    n_failed;
    int    done_cycle [0:1];
    int    last_lat [0:1];

    assign m0_req = req[0];
    assign m1_req = req[1];
    assign rsp[0] = m0_rsp;
    assign rsp[1] = m1_rsp;

    periph_top uut (
        .clk       (clk),
        .rst_reg_n (rst_reg_n),
        .m0_req    (m0_req),
        .m0_rsp    (m0_rsp),
        .m1_req    (m1_req),
        .m1_rsp    (m1_rsp),
        .gpio_in   (gpio_in),
        .uo_out    (uo_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic check_data(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_resp(input string name, input axil_resp_e got, input axil_resp_e exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %s expected %s", $time, name, got.name(), exp.name());
            errors++;
        end
    endtask

    task automatic check_pins(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got 0x%02h expected 0x%02h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        n_tests++;
        if (errors > err_mark) begin
            n_failed++;
            $display("Test %s: %0d error(s)", name, errors - err_mark);
        end else begin
            $display("Test %s: ok", name);
        end
        err_mark = errors;
    endtask

    // Pin mux as the register map defines it
    function automatic logic [7:0] expected_pins(input logic [7:0] out, input logic [8:0] sel,
                                                 input logic txd, input logic pwm);
        logic [7:0] pins;
        pins    = 8'h00;
        pins[0] = sel[0] ? out[0] : txd;
        for (int b = 1; b <= 6; b++) begin
            if (sel[b])
                pins[b] = out[b];
        end
        if (sel[8])
            pins[7] = pwm;
        else if (sel[7])
            pins[7] = out[7];
        return pins;
    endfunction

    task automatic add_step(input logic m, input logic wr, input logic [7:0] addr,
                            input logic [31:0] wdata, input logic [31:0] rdata,
                            input axil_resp_e resp);
        tbl[n_steps].m     = m;
        tbl[n_steps].wr    = wr;
        tbl[n_steps].addr  = addr;
        tbl[n_steps].wdata = wdata;
        tbl[n_steps].rdata = rdata;
        tbl[n_steps].resp  = resp;
        n_steps++;
    endtask

    task automatic write_bus(input int m, input logic [7:0] addr, input logic [31:0] data,
                             output axil_resp_e resp);
        int start;
        @(posedge clk);
        #1;
        start            = cycle;
        req[m].awaddr    = addr;
        req[m].wdata     = data;
        req[m].wstrb     = 4'hF;
        req[m].awvalid   = 1'b1;
        req[m].wvalid    = 1'b1;
        req[m].bready    = 1'b1;
        @(negedge clk);
        while (!rsp[m].awready) @(negedge clk);
        @(posedge clk);
        #1;
        req[m].awvalid = 1'b0;
        req[m].wvalid  = 1'b0;
        @(negedge clk);
        while (!rsp[m].bvalid) @(negedge clk);
        last_lat[m] = cycle - start;
        resp        = rsp[m].bresp;
        @(posedge clk);
        #1;
        done_cycle[m]  = cycle;
        req[m].bready  = 1'b0;
    endtask

    // Holds rready low for hold cycles once rvalid is up
    task automatic read_bus(input int m, input logic [7:0] addr, input int hold,
                            output logic [31:0] data, output axil_resp_e resp);
        int start;
        @(posedge clk);
        #1;
        start          = cycle;
        req[m].araddr  = addr;
        req[m].arvalid = 1'b1;
        req[m].rready  = (hold == 0);
        @(negedge clk);
        while (!rsp[m].arready) @(negedge clk);
        @(posedge clk);
        #1;
        req[m].arvalid = 1'b0;
        @(negedge clk);
        while (!rsp[m].rvalid) @(negedge clk);
        last_lat[m] = cycle - start;
        data        = rsp[m].rdata;
        resp        = rsp[m].rresp;
        repeat (hold) begin
            @(negedge clk);
            check_count("rvalid held", rsp[m].rvalid, 1);
            check_data("rdata held", rsp[m].rdata, data);
        end
        if (hold > 0) begin
            @(posedge clk);
            #1;
            req[m].rready = 1'b1;
        end
        @(posedge clk);
        #1;
        done_cycle[m] = cycle;
        req[m].rready = 1'b0;
    endtask

    // Start bit found at its first cycle, then each bit sampled mid-period
    task automatic receive_frame(output logic [7:0] rx, output logic start_bit,
                                 output logic stop_bit);
        @(negedge clk);
        while (uo_out[0]) @(negedge clk);
        repeat (UART_CLKS_PER_BIT / 2) @(negedge clk);
        start_bit = uo_out[0];
        for (int i = 0; i < 8; i++) begin
            repeat (UART_CLKS_PER_BIT) @(negedge clk);
            rx[i] = uo_out[0];
        end
        repeat (UART_CLKS_PER_BIT) @(negedge clk);
        stop_bit = uo_out[0];
    endtask

    // Caller stands on the negedge of the first cycle of a period
    task automatic count_pwm_window(output int high);
        high = 0;
        for (int i = 0; i < PWM_PERIOD; i++) begin
            if (i > 0)
                @(negedge clk);
            if (uo_out[7])
                high++;
        end
    endtask

    initial begin
        logic [31:0] r_out;
        logic [31:0] r_sel;
        logic [31:0] data;
        logic [7:0]  pins;
        logic [7:0]  cur_out;
        logic [8:0]  cur_sel;
        logic [7:0]  byte_a;
        logic [7:0]  rx;
        logic        start_bit;
        logic        stop_bit;
        axil_resp_e  resp;
        axil_resp_e  resp_b;
        int          n;

        void'($urandom(32'ha6b6));
        rst_reg_n = 1'b0;
        req[0]    = '0;
        req[1]    = '0;
        gpio_in   = 8'h00;
        cycle     = 0;
        errors    = 0;
        err_mark  = 0;
        n_tests   = 0;
        n_failed  = 0;
        n_steps   = 0;
        repeat (5) @(posedge clk);
        #1;
        rst_reg_n = 1'b1;
        gpio_in   = $urandom;

        // Register table; UART idle and PWM level 0 while it runs
        r_out = $urandom;
        r_sel = $urandom;
        pins  = expected_pins(r_out[7:0], r_sel[8:0], 1'b1, 1'b0);
        add_step(0, 1, ADDR_GPIO_SEL, r_sel, 32'h0, OKAY);
        add_step(0, 1, ADDR_GPIO_OUT, r_out, 32'h0, OKAY);
        add_step(1, 0, ADDR_GPIO_SEL, 32'h0, {23'h0, r_sel[8:0]}, OKAY);
        add_step(0, 0, ADDR_GPIO_OUT, 32'h0, {24'h0, pins}, OKAY);
        add_step(1, 0, ADDR_GPIO_IN, 32'h0, {24'h0, gpio_in}, OKAY);
        add_step(0, 0, ADDR_UART_DATA, 32'h0, 32'h0, OKAY);
        add_step(1, 0, ADDR_UART_STATUS, 32'h0, 32'h0, OKAY);
        add_step(0, 0, ADDR_PWM, 32'h0, 32'h0, OKAY);
        add_step(1, 0, 8'h08, 32'h0, 32'hFFFF_FFFF, SLVERR);
        add_step(0, 0, 8'hFC, 32'h0, 32'hFFFF_FFFF, SLVERR);
        add_step(1, 1, 8'h30, $urandom, 32'h0, SLVERR);
        add_step(0, 1, 8'h08, $urandom, 32'h0, SLVERR);
        add_step(1, 0, ADDR_GPIO_SEL, 32'h0, {23'h0, r_sel[8:0]}, OKAY);
        add_step(0, 0, ADDR_GPIO_OUT, 32'h0, {24'h0, pins}, OKAY);
        add_step(1, 0, ADDR_PWM, 32'h0, 32'h0, OKAY);

        // GPIO registers as written so far
        cur_out = 8'h00;
        cur_sel = 9'h000;
        for (int i = 0; i < n_steps; i++) begin
            if (tbl[i].wr) begin
                write_bus(tbl[i].m, tbl[i].addr, tbl[i].wdata, resp);
                check_resp("bresp", resp, tbl[i].resp);
                if (tbl[i].addr == ADDR_GPIO_OUT)
                    cur_out = tbl[i].wdata[7:0];
                if (tbl[i].addr == ADDR_GPIO_SEL)
                    cur_sel = tbl[i].wdata[8:0];
            end else begin
                read_bus(tbl[i].m, tbl[i].addr, 0, data, resp);
                check_data("rdata", data, tbl[i].rdata);
                check_resp("rresp", resp, tbl[i].resp);
            end
            check_count("latency", last_lat[tbl[i].m], 2);
            check_pins("uo_out", uo_out, expected_pins(cur_out, cur_sel, 1'b1, 1'b0));
            end_test($sformatf("step %0d master %0d %s 0x%02h", i, tbl[i].m,
                               tbl[i].wr ? "write" : "read", tbl[i].addr));
        end

        // UART frame, with a second byte sent while busy
        write_bus(0, ADDR_GPIO_SEL, 32'h0, resp);
        byte_a = $urandom;
        fork
            receive_frame(rx, start_bit, stop_bit);
            begin
                write_bus(0, ADDR_UART_DATA, {24'h0, byte_a}, resp);
                check_resp("bresp", resp, OKAY);
                write_bus(1, ADDR_UART_DATA, {24'h0, ~byte_a}, resp);
                check_resp("bresp while busy", resp, OKAY);
                read_bus(0, ADDR_UART_STATUS, 0, data, resp);
                check_data("uart status in frame", data, 32'h1);
            end
        join
        check_count("start bit", start_bit, 0);
        check_data("uart byte", {24'h0, rx}, {24'h0, byte_a});
        check_count("stop bit", stop_bit, 1);
        repeat (UART_CLKS_PER_BIT / 2 + 1) @(posedge clk);
        read_bus(1, ADDR_UART_STATUS, 0, data, resp);
        check_data("uart status after frame", data, 32'h0);
        end_test("uart frame");

        // PWM duty over whole periods, next level written during each window
        write_bus(0, ADDR_GPIO_SEL, 32'h100, resp);
        write_bus(1, ADDR_PWM, 32'd64, resp);
        @(negedge clk);
        while (!uo_out[7]) @(negedge clk);
        fork
            count_pwm_window(n);
            write_bus(0, ADDR_PWM, 32'd200, resp);
        join
        check_count("pwm high cycles at level 64", n, 64);
        @(negedge clk);
        fork
            count_pwm_window(n);
            write_bus(1, ADDR_PWM, 32'd0, resp);
        join
        check_count("pwm high cycles at level 200", n, 200);
        @(negedge clk);
        count_pwm_window(n);
        check_count("pwm high cycles at level 0", n, 0);
        read_bus(0, ADDR_PWM, 0, data, resp);
        check_data("pwm level", data, 32'h0);
        end_test("pwm duty");

        // Master 1 served last, so master 0 wins the first tie
        read_bus(1, ADDR_PWM, 0, data, resp);
        r_sel = $urandom;
        r_out = $urandom;
        fork
            write_bus(0, ADDR_GPIO_SEL, r_sel, resp);
            write_bus(1, ADDR_GPIO_OUT, r_out, resp_b);
        join
        check_resp("bresp master 0", resp, OKAY);
        check_resp("bresp master 1", resp_b, OKAY);
        check_count("first pair served first", done_cycle[0] < done_cycle[1] ? 0 : 1, 0);
        pins = expected_pins(r_out[7:0], r_sel[8:0], 1'b1, 1'b0);
        read_bus(1, ADDR_GPIO_OUT, 0, data, resp);
        check_data("gpio_out readback", data, {24'h0, pins});
        read_bus(0, ADDR_GPIO_SEL, 0, data, resp);
        check_data("gpio_sel readback", data, {23'h0, r_sel[8:0]});
        r_sel = $urandom;
        r_out = $urandom;
        fork
            write_bus(0, ADDR_GPIO_OUT, r_out, resp);
            write_bus(1, ADDR_GPIO_SEL, r_sel, resp_b);
        join
        check_resp("bresp master 0", resp, OKAY);
        check_resp("bresp master 1", resp_b, OKAY);
        check_count("second pair served first", done_cycle[0] < done_cycle[1] ? 0 : 1, 1);
        pins = expected_pins(r_out[7:0], r_sel[8:0], 1'b1, 1'b0);
        read_bus(0, ADDR_GPIO_OUT, 0, data, resp);
        check_data("gpio_out readback", data, {24'h0, pins});
        read_bus(1, ADDR_GPIO_SEL, 0, data, resp);
        check_data("gpio_sel readback", data, {23'h0, r_sel[8:0]});
        end_test("arbitration");

        // Read held off by rready while master 1 waits with a write
        r_out = $urandom;
        fork
            read_bus(0, ADDR_GPIO_SEL, 6, data, resp);
            begin
                @(posedge clk);
                write_bus(1, ADDR_GPIO_OUT, r_out, resp);
            end
        join
        check_data("held read data", data, {23'h0, r_sel[8:0]});
        check_count("write done after held read", done_cycle[1] > done_cycle[0], 1);
        pins = expected_pins(r_out[7:0], r_sel[8:0], 1'b1, 1'b0);
        read_bus(0, ADDR_GPIO_OUT, 0, data, resp);
        check_data("gpio_out readback", data, {24'h0, pins});
        end_test("back-pressure");

        $display("Tests run %0d, failed %0d, check errors %0d", n_tests, n_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
design/periph_pkg.sv
design/axil_arbiter.sv
design/periph_regs.sv
design/uart_tx.sv
design/pwm_ctrl.sv
design/periph_top.sv
dv/periph_tb.sv

// ==== Bender.yml ====
package:
  name: periph

sources:
  - design/periph_pkg.sv
  - design/axil_arbiter.sv
  - design/periph_regs.sv
  - design/uart_tx.sv
  - design/pwm_ctrl.sv
  - design/periph_top.sv
  - target: simulation
    files:
      - dv/periph_tb.sv
